// ==== design/am_lock_pkg.sv ====
package am_lock_pkg;

	// 802.3ba defines one marker per PCS lane, 20 in total
	localparam int N_PCS_LANES = 20;

	localparam int AM_WIDTH = 48;
	localparam int LANE_ID_W = 5;

	typedef logic [AM_WIDTH-1:0] am_value_t;
	typedef logic [N_PCS_LANES-1:0] lane_mask_t;
	typedef logic [LANE_ID_W-1:0] lane_id_t;

	// One received 66-bit block, reduced to the fields used for marker lock
	typedef struct packed
	{
		logic sh_valid;
		am_value_t am_value;
	} blk_t;

	// Request from a lane FSM to the shared comparator
	typedef struct packed
	{
		am_value_t am_value;
		lane_mask_t match_mask;
		logic enable_mask;
		logic timer_done;
		logic sh_valid;
	} am_req_t;

	// Comparator result, broadcast back to all lanes
	typedef struct packed
	{
		logic am_match;
		lane_mask_t match_vector;
	} am_rsp_t;

	typedef enum logic [1:0]
	{
		SEARCH,
		COUNT_1,
		COMP_2ND,
		LOCKED
	} lock_state_e;

endpackage

// ==== design/am_lock_comparator.sv ====
`timescale 1ns/1ps

module am_lock_comparator
(
	input  am_lock_pkg::am_value_t i_am_value,
	input  am_lock_pkg::lane_mask_t i_match_mask,
	input  logic i_enable_mask,
	input  logic i_timer_done,
	input  logic i_sh_valid,
	output logic o_am_match,
	output am_lock_pkg::lane_mask_t o_match_vector
);

	// Marker fields M0 M1 M2 M4 M5 M6 for PCS lanes 0 to 19
	localparam am_lock_pkg::am_value_t AM_TABLE [am_lock_pkg::N_PCS_LANES] = '{
		48'hC168213E97DE,
		48'h9D718E628E71,
		48'h594BE8A6B417,
		48'h4D957BB26A84,
		48'hF507090AF8F6,
		48'hDD14C222EB3D,
		48'h9A4A2665B5D9,
		48'h7B456684BA99,
		48'hA024765FDB89,
		48'h68C9FB973604,
		48'hFD6C99029366,
		48'hB99155466EAA,
		48'h5CB9B2A3464D,
		48'h1AF8BDE50742,
		48'h83C7CA7C3835,
		48'h3536CDCAC932,
		48'hC4314C3BCEB3,
		48'hADD6B7522948,
		48'h5F662AA099D5,
		48'hC0F0E53F0F1A
	};

	am_lock_pkg::lane_mask_t hit;

	always_comb
	begin
		hit = '0;
		for (int i = 0; i < am_lock_pkg::N_PCS_LANES; i++)
		begin
			if ((AM_TABLE[i] == i_am_value) && i_match_mask[i])
				hit[i] = 1'b1;
		end
	end

	assign o_match_vector = hit;

	// A hit counts only at a search or expected position with a good sync header
	assign o_am_match = (|hit) & (i_timer_done | i_enable_mask) & i_sh_valid;

endmodule

// ==== design/am_request_arbiter.sv ====
`timescale 1ns/1ps

module am_request_arbiter
#(
	parameter int N_LANES = 4
)
(
	input  logic i_clk,
	input  logic i_reset,
	input  logic [N_LANES-1:0] i_req,
	input  am_lock_pkg::am_req_t [N_LANES-1:0] i_req_data,
	output logic [N_LANES-1:0] o_grant,
	output am_lock_pkg::am_rsp_t o_rsp
);

	localparam int PTR_W = (N_LANES > 1) ? $clog2(N_LANES) : 1;

	typedef logic [PTR_W-1:0] slot_t;

	slot_t ptr;
	slot_t sel;
	logic any_req;
	int idx;
	am_lock_pkg::am_req_t req_sel;

	// Scan from the far end so the nearest requester at or after ptr wins
	always_comb
	begin
		sel = ptr;
		any_req = 1'b0;
		idx = 0;
		for (int off = N_LANES - 1; off >= 0; off--)
		begin
			idx = (int'(ptr) + off) % N_LANES;
			if (i_req[idx])
			begin
				sel = slot_t'(idx);
				any_req = 1'b1;
			end
		end
	end

	always_comb
	begin
		o_grant = '0;
		if (any_req)
			o_grant[sel] = 1'b1;
	end

	assign req_sel = i_req_data[sel];

	am_lock_comparator am_lock_comparator_i
	(
		.i_am_value     (req_sel.am_value),
		.i_match_mask   (req_sel.match_mask),
		.i_enable_mask  (req_sel.enable_mask),
		.i_timer_done   (req_sel.timer_done),
		.i_sh_valid     (req_sel.sh_valid),
		.o_am_match     (o_rsp.am_match),
		.o_match_vector (o_rsp.match_vector)
	);

	// Move past the served slot
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			ptr <= '0;
		else if (any_req)
			ptr <= (sel == slot_t'(N_LANES - 1)) ? '0 : sel + slot_t'(1);
	end

endmodule

// ==== design/am_lane_lock.sv ====
`timescale 1ns/1ps

module am_lane_lock
#(
	parameter int AM_SPACING = 16,
	parameter int BAD_LIMIT = 4
)
(
	input  logic i_clk,
	input  logic i_reset,
	input  logic i_blk_valid,
	input  am_lock_pkg::blk_t i_blk,
	input  logic i_grant,
	input  am_lock_pkg::am_rsp_t i_rsp,
	output logic o_req,
	output am_lock_pkg::am_req_t o_req_data,
	output logic o_am_lock,
	output am_lock_pkg::lane_id_t o_lane_id
);

	localparam int CNT_W = $clog2(AM_SPACING + 1);
	localparam int BAD_W = $clog2(BAD_LIMIT + 1);

	typedef logic [CNT_W-1:0] blk_cnt_t;
	typedef logic [BAD_W-1:0] bad_cnt_t;

	// Counter value on the block just before the expected marker
	localparam blk_cnt_t LAST_BLK = blk_cnt_t'(AM_SPACING - 1);
	localparam bad_cnt_t BAD_LAST = bad_cnt_t'(BAD_LIMIT - 1);

	am_lock_pkg::lock_state_e state;
	am_lock_pkg::blk_t pend_blk;
	am_lock_pkg::lane_id_t lane_id;
	am_lock_pkg::lane_mask_t id_mask;
	blk_cnt_t blk_cnt;
	bad_cnt_t bad_cnt;
	logic check_pos;

	function automatic am_lock_pkg::lane_id_t vec_to_id(input am_lock_pkg::lane_mask_t vec);
		am_lock_pkg::lane_id_t id;
		id = '0;
		for (int i = am_lock_pkg::N_PCS_LANES - 1; i >= 0; i--)
		begin
			if (vec[i])
				id = am_lock_pkg::lane_id_t'(i);
		end
		return id;
	endfunction

	assign id_mask = am_lock_pkg::lane_mask_t'(1) << lane_id;

	assign check_pos = (state == am_lock_pkg::COMP_2ND) ||
		((state == am_lock_pkg::LOCKED) && (blk_cnt == LAST_BLK));

	always_comb
	begin
		o_req_data.am_value = pend_blk.am_value;
		o_req_data.sh_valid = pend_blk.sh_valid;
		o_req_data.timer_done = check_pos;
		if (state == am_lock_pkg::SEARCH)
		begin
			o_req_data.enable_mask = 1'b1;
			o_req_data.match_mask = '1;
		end
		else
		begin
			o_req_data.enable_mask = 1'b0;
			o_req_data.match_mask = id_mask;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_blk_valid)
			pend_blk <= i_blk;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_req <= 1'b0;
			state <= am_lock_pkg::SEARCH;
			blk_cnt <= '0;
			bad_cnt <= '0;
			lane_id <= '0;
		end
		else
		begin
			if (i_grant)
				o_req <= 1'b0;
			else if (i_blk_valid)
				o_req <= 1'b1;

			if (i_grant)
			begin
				case (state)
					am_lock_pkg::SEARCH:
					begin
						if (i_rsp.am_match)
						begin
							lane_id <= vec_to_id(i_rsp.match_vector);
							blk_cnt <= '0;
							bad_cnt <= '0;
							state <= (AM_SPACING == 1) ? am_lock_pkg::COMP_2ND
								: am_lock_pkg::COUNT_1;
						end
					end
					am_lock_pkg::COUNT_1:
					begin
						blk_cnt <= blk_cnt + blk_cnt_t'(1);
						if (blk_cnt + blk_cnt_t'(1) == LAST_BLK)
							state <= am_lock_pkg::COMP_2ND;
					end
					am_lock_pkg::COMP_2ND:
					begin
						blk_cnt <= '0;
						bad_cnt <= '0;
						state <= i_rsp.am_match ? am_lock_pkg::LOCKED : am_lock_pkg::SEARCH;
					end
					am_lock_pkg::LOCKED:
					begin
						if (blk_cnt == LAST_BLK)
						begin
							blk_cnt <= '0;
							if (i_rsp.am_match)
								bad_cnt <= '0;
							else if (bad_cnt == BAD_LAST)
							begin
								bad_cnt <= '0;
								state <= am_lock_pkg::SEARCH;
							end
							else
								bad_cnt <= bad_cnt + bad_cnt_t'(1);
						end
						else
							blk_cnt <= blk_cnt + blk_cnt_t'(1);
					end
					default:
						state <= am_lock_pkg::SEARCH;
				endcase
			end
		end
	end

	assign o_am_lock = (state == am_lock_pkg::LOCKED);
	assign o_lane_id = lane_id;

endmodule

// ==== design/am_lock_top.sv ====
`timescale 1ns/1ps

module am_lock_top
#(
	parameter int N_LANES = 4,
	parameter int AM_SPACING = 16,
	parameter int BAD_LIMIT = 4
)
(
	input  logic i_clk,
	input  logic i_reset,
	input  logic [N_LANES-1:0] i_blk_valid,
	input  am_lock_pkg::blk_t [N_LANES-1:0] i_blk,
	output logic [N_LANES-1:0] o_am_lock,
	output am_lock_pkg::lane_id_t [N_LANES-1:0] o_lane_id
);

	logic [N_LANES-1:0] lane_req;
	logic [N_LANES-1:0] lane_grant;
	am_lock_pkg::am_req_t [N_LANES-1:0] lane_req_data;
	am_lock_pkg::am_rsp_t cmp_rsp;

	genvar g;

	// One lock FSM per physical lane slot
	generate
		for (g = 0; g < N_LANES; g++)
		begin : g_lane
			am_lane_lock
			#(
				.AM_SPACING (AM_SPACING),
				.BAD_LIMIT  (BAD_LIMIT)
			)
			am_lane_lock_i
			(
				.i_clk       (i_clk),
				.i_reset     (i_reset),
				.i_blk_valid (i_blk_valid[g]),
				.i_blk       (i_blk[g]),
				.i_grant     (lane_grant[g]),
				.i_rsp       (cmp_rsp),
				.o_req       (lane_req[g]),
				.o_req_data  (lane_req_data[g]),
				.o_am_lock   (o_am_lock[g]),
				.o_lane_id   (o_lane_id[g])
			);
		end
	endgenerate

	am_request_arbiter
	#(
		.N_LANES (N_LANES)
	)
	am_request_arbiter_i
	(
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_req      (lane_req),
		.i_req_data (lane_req_data),
		.o_grant    (lane_grant),
		.o_rsp      (cmp_rsp)
	);

endmodule

// ==== verif/am_lock_assertions.sv ====
`timescale 1ns/1ps

module am_lock_assertions
#(
	parameter int N_LANES = 4
)
(
	input logic i_clk,
	input logic i_reset,
	input logic [N_LANES-1:0] i_req,
	input logic [N_LANES-1:0] i_grant
);

	a_grant_onehot: assert property (@(posedge i_clk) disable iff (i_reset) $onehot0(i_grant))
		else $error("arbiter granted more than one slot");

	a_grant_to_req: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_grant & ~i_req) == '0)
		else $error("arbiter granted a slot without a request");

	genvar g;

	generate
		for (g = 0; g < N_LANES; g++)
		begin : g_hold
			a_req_held: assert property (@(posedge i_clk) disable iff (i_reset)
				(i_req[g] && !i_grant[g]) |=> i_req[g])
				else $error("slot %0d dropped its request before a grant", g);
		end
	endgenerate

endmodule

bind am_lock_top am_lock_assertions
#(
	.N_LANES (N_LANES)
)
am_lock_assertions_i
(
	.i_clk   (i_clk),
	.i_reset (i_reset),
	.i_req   (lane_req),
	.i_grant (lane_grant)
);

// ==== verif/am_lock_tb.sv ====
`timescale 1ns/1ps

module am_lock_tb;

	localparam int N_LANES = 4;
	localparam int AM_SPACING = 16;
	localparam int BAD_LIMIT = 4;
	localparam int NPL = am_lock_pkg::N_PCS_LANES;

	// Block kinds sent at a marker position
	localparam int K_GOOD = 0;
	localparam int K_OTHER = 1;
	localparam int K_FILL = 2;
	localparam int K_SH_BAD = 3;

	localparam int M_SEARCH = 0;
	localparam int M_COUNT = 1;
	localparam int M_LOCKED = 2;

	localparam am_lock_pkg::am_value_t AM_REF [NPL] = '{
		48'hC168213E97DE, 48'h9D718E628E71, 48'h594BE8A6B417, 48'h4D957BB26A84,
		48'hF507090AF8F6, 48'hDD14C222EB3D, 48'h9A4A2665B5D9, 48'h7B456684BA99,
		48'hA024765FDB89, 48'h68C9FB973604, 48'hFD6C99029366, 48'hB99155466EAA,
		48'h5CB9B2A3464D, 48'h1AF8BDE50742, 48'h83C7CA7C3835, 48'h3536CDCAC932,
		48'hC4314C3BCEB3, 48'hADD6B7522948, 48'h5F662AA099D5, 48'hC0F0E53F0F1A
	};

	// Marker period sequence and the lock state expected at the end of each period
	localparam int SCRIPT [19] = '{
		K_SH_BAD, K_GOOD, K_OTHER, K_GOOD, K_FILL, K_GOOD, K_SH_BAD, K_GOOD, K_GOOD,
		K_OTHER, K_FILL, K_SH_BAD, K_GOOD, K_OTHER, K_FILL, K_SH_BAD, K_OTHER, K_GOOD, K_GOOD
	};
	localparam logic [18:0] SCRIPT_LOCK = 19'b100_1111_1111_0000_0000;

	logic i_clk = 1'b0;
	logic i_reset;
	logic [N_LANES-1:0] i_blk_valid;
	am_lock_pkg::blk_t [N_LANES-1:0] i_blk;
	logic [N_LANES-1:0] o_am_lock;
	am_lock_pkg::lane_id_t [N_LANES-1:0] o_lane_id;

	logic [31:0] rng = 32'h7d62;
	int lane_of [N_LANES];
	int kind [N_LANES];
	int m_state [N_LANES];
	int m_cnt [N_LANES];
	int m_bad [N_LANES];
	am_lock_pkg::lane_id_t m_id [N_LANES];
	int n_checks = 0;
	event round_done;

	am_lock_top
	#(
		.N_LANES    (N_LANES),
		.AM_SPACING (AM_SPACING),
		.BAD_LIMIT  (BAD_LIMIT)
	)
	am_lock_top_i
	(
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_blk_valid (i_blk_valid),
		.i_blk       (i_blk),
		.o_am_lock   (o_am_lock),
		.o_lane_id   (o_lane_id)
	);

	initial
	begin
		forever
			#50 i_clk = ~i_clk;
	end

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng = x;
		return x;
	endfunction

	function automatic int marker_index(input am_lock_pkg::am_value_t v);
		int idx;
		idx = -1;
		for (int i = 0; i < NPL; i++)
			if (AM_REF[i] == v)
				idx = i;
		return idx;
	endfunction

	function automatic am_lock_pkg::blk_t make_blk(input int s, input int k);
		am_lock_pkg::blk_t b;
		logic [31:0] r;
		r = xorshift32();
		// Fillers get an occasional corrupted sync header
		b.sh_valid = (k != K_SH_BAD) && ((k != K_FILL) || (r[2:0] != 3'd0));
		if (k == K_GOOD || k == K_SH_BAD)
			b.am_value = AM_REF[lane_of[s]];
		else if (k == K_OTHER)
			b.am_value = AM_REF[(lane_of[s] + 1 + int'(r % 32'd19)) % NPL];
		else
		begin
			do
				b.am_value = {xorshift32(), r[15:0]};
			while (marker_index(b.am_value) >= 0);
		end
		return b;
	endfunction

	function automatic void ref_lane_step(input int s, input am_lock_pkg::blk_t b);
		int hit;
		logic good;
		hit = b.sh_valid ? marker_index(b.am_value) : -1;
		if (m_state[s] == M_SEARCH)
		begin
			if (hit >= 0)
			begin
				m_id[s] = am_lock_pkg::lane_id_t'(hit);
				m_cnt[s] = 0;
				m_bad[s] = 0;
				m_state[s] = M_COUNT;
			end
		end
		else
		begin
			m_cnt[s] = m_cnt[s] + 1;
			if (m_cnt[s] == AM_SPACING)
			begin
				// Expected marker position
				m_cnt[s] = 0;
				good = (hit == int'(m_id[s]));
				if (m_state[s] == M_COUNT)
					m_state[s] = good ? M_LOCKED : M_SEARCH;
				else if (good)
					m_bad[s] = 0;
				else
				begin
					m_bad[s] = m_bad[s] + 1;
					if (m_bad[s] == BAD_LIMIT)
						m_state[s] = M_SEARCH;
				end
			end
		end
	endfunction

	task automatic check_lock(input int slot, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("[FAIL] o_am_lock[%0d] got %h expected %h", slot, got, exp);
			$display("Test failed");
			$fatal(1, "lock status differs from the expected value");
		end
	endtask

	task automatic check_lane_id(input int slot, input am_lock_pkg::lane_id_t got,
		input am_lock_pkg::lane_id_t exp);
		if (got !== exp)
		begin
			$display("[FAIL] o_lane_id[%0d] got %h expected %h", slot, got, exp);
			$display("Test failed");
			$fatal(1, "lane id differs from the expected value");
		end
	endtask

	// One block to every slot, then wait until all requests are served
	task automatic run_round();
		am_lock_pkg::blk_t blk [N_LANES];
		int waited;
		for (int s = 0; s < N_LANES; s++)
			blk[s] = make_blk(s, kind[s]);
		@(posedge i_clk);
		i_blk_valid <= '1;
		for (int s = 0; s < N_LANES; s++)
			i_blk[s] <= blk[s];
		@(posedge i_clk);
		i_blk_valid <= '0;
		waited = 0;
		do
		begin
			@(negedge i_clk);
			waited = waited + 1;
			if (waited > N_LANES + 2)
			begin
				$display("Test failed");
				$fatal(1, "lane requests were not all granted in time");
			end
		end
		while (am_lock_top_i.lane_req != '0);
		for (int s = 0; s < N_LANES; s++)
			ref_lane_step(s, blk[s]);
		-> round_done;
	endtask

	task automatic send_period();
		run_round();
		for (int s = 0; s < N_LANES; s++)
			kind[s] = K_FILL;
		repeat (AM_SPACING - 1)
			run_round();
	endtask

	always @(round_done)
	begin
		for (int s = 0; s < N_LANES; s++)
		begin
			check_lock(s, o_am_lock[s], m_state[s] == M_LOCKED);
			check_lane_id(s, o_lane_id[s], m_id[s]);
		end
		n_checks = n_checks + 1;
	end

	initial
	begin
		logic [31:0] r;
		int base;
		i_reset <= 1'b1;
		i_blk_valid <= '0;
		i_blk <= '0;
		for (int s = 0; s < N_LANES; s++)
		begin
			m_state[s] = M_SEARCH;
			m_cnt[s] = 0;
			m_bad[s] = 0;
			m_id[s] = '0;
			kind[s] = K_FILL;
		end
		repeat (10)
			@(posedge i_clk);
		i_reset <= 1'b0;
		@(negedge i_clk);
		for (int s = 0; s < N_LANES; s++)
			check_lock(s, o_am_lock[s], 1'b0);
		repeat (20)
			run_round();
		base = int'(xorshift32() % 32'd20);
		for (int s = 0; s < N_LANES; s++)
			lane_of[s] = (base + s * 7) % NPL;
		for (int p = 0; p < 19; p++)
		begin
			for (int s = 0; s < N_LANES; s++)
				kind[s] = SCRIPT[p];
			send_period();
			for (int s = 0; s < N_LANES; s++)
				check_lock(s, o_am_lock[s], SCRIPT_LOCK[p]);
		end
		// New ids per slot, then mostly good markers mixed with bad ones
		base = int'(xorshift32() % 32'd20);
		for (int s = 0; s < N_LANES; s++)
			lane_of[s] = (base + s * 7) % NPL;
		repeat (30)
		begin
			for (int s = 0; s < N_LANES; s++)
			begin
				r = xorshift32();
				kind[s] = (r[2:0] < 3'd5) ? K_GOOD : int'(r[4:3]);
			end
			send_period();
		end
		@(posedge i_clk);
		if (n_checks == 0)
		begin
			$display("Test failed");
			$fatal(1, "no round was compared");
		end
		else
		begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

// ==== am_lock.f ====
design/am_lock_pkg.sv
design/am_lock_comparator.sv
design/am_request_arbiter.sv
design/am_lane_lock.sv
design/am_lock_top.sv
verif/am_lock_assertions.sv
verif/am_lock_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module am_lock_tb -f am_lock.f -o am_lock_sim
./obj_dir/am_lock_sim
